//--- mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ==================================================
// Stage-wide sizes
// ==================================================

// Data and byte address width
`define MEM_XLEN 32

// One strobe bit per byte lane
`define MEM_STRB_W 4

// Destination register number
`define MEM_RD_W 5

// Retire queue entries, also the credits held at reset
`define MEM_FIFO_DEPTH 4

// Credit counter must reach MEM_FIFO_DEPTH itself
`define MEM_CREDIT_W 3

`endif

//--- mem_op_pkg.sv
`default_nettype none

`include "mem_params.svh"

// ==================================================
// Instruction-level types for loads and stores
// ==================================================
package mem_op_pkg;

  // Access size from funct3[1:0]
  // funct3[2] selects zero extension on loads
  typedef enum logic [1:0] {
    MEM_SIZE_B = 2'b00,
    MEM_SIZE_H = 2'b01,
    MEM_SIZE_W = 2'b10
  } mem_size_e;

  // Trap codes raised by this stage
  typedef enum logic [1:0] {
    MEM_TRAP_NONE     = 2'b00,
    MEM_TRAP_MISALIGN = 2'b01
  } mem_trap_e;

  // One load or store request
  typedef struct packed {
    // High for stores
    logic                 is_write;
    // Size in [1:0], unsigned load in [2]
    logic [2:0]           funct3;
    // Effective byte address
    logic [`MEM_XLEN-1:0] addr;
    // Store data, low bytes used for B/H
    logic [`MEM_XLEN-1:0] wdata;
    // Load destination
    logic [`MEM_RD_W-1:0] rd;
  } mem_req_t;

endpackage

`default_nettype wire

//--- mem_pipe_pkg.sv
`default_nettype none

`include "mem_params.svh"

// ==================================================
// Types that live inside the stage
// ==================================================
package mem_pipe_pkg;

  import mem_op_pkg::*;

  // One memory word, seen as byte lanes or halfword lanes
  typedef union packed {
    logic [`MEM_STRB_W-1:0][7:0]      lane_b;
    logic [`MEM_STRB_W/2-1:0][15:0]   lane_h;
  } mem_word_u;

  // Retired operation waiting for writeback
  typedef struct packed {
    logic                 is_load;
    logic [2:0]           funct3;
    // Byte offset inside the word
    logic [1:0]           addr_lo;
    logic [`MEM_RD_W-1:0] rd;
    // Raw word as read in the access cycle
    mem_word_u            rdata;
    logic                 trap;
    mem_trap_e            trap_code;
  } mem_entry_t;

  // Result presented at the writeback port
  typedef struct packed {
    logic [`MEM_RD_W-1:0] rd;
    logic                 reg_write;
    logic [`MEM_XLEN-1:0] data;
    logic                 trap;
    mem_trap_e            trap_code;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- mem_access_unit.sv
`default_nettype none

`include "mem_params.svh"

module mem_access_unit
  import mem_op_pkg::*;
  import mem_pipe_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid_i,
  input  mem_req_t               req_i,
  output logic                   req_ready_o,
  output logic                   dmem_ren_o,
  output logic                   dmem_we_o,
  output logic [`MEM_XLEN-1:0]   dmem_addr_o,
  output logic [`MEM_XLEN-1:0]   dmem_wdata_o,
  output logic [`MEM_STRB_W-1:0] dmem_wstrb_o,
  input  logic [`MEM_XLEN-1:0]   dmem_rdata_i,
  input  logic                   credit_return_i,
  output logic                   push_o,
  output mem_entry_t             entry_o
);

  mem_size_e               req_size;
  logic                    misalign;
  logic                    accept;
  mem_word_u               st_word;
  logic [`MEM_STRB_W-1:0]  st_strb;
  logic [`MEM_CREDIT_W-1:0] credit_cnt;

  // ==================================================
  // Size decode and alignment
  // ==================================================
  assign req_size = mem_size_e'(req_i.funct3[1:0]);

  always_comb begin
    case (req_size)
      MEM_SIZE_B: misalign = 1'b0;
      MEM_SIZE_H: misalign = req_i.addr[0];
      // Word, and the unused size code treated as word
      default:    misalign = |req_i.addr[1:0];
    endcase
  end

  // Only with a credit in hand
  assign req_ready_o = (credit_cnt != '0);
  assign accept      = req_valid_i && req_ready_o;

  // ==================================================
  // Store lane placement
  // ==================================================
  always_comb begin
    st_word = '0;
    st_strb = '0;
    case (req_size)
      MEM_SIZE_B: begin
        // Byte goes to the lane picked by addr[1:0]
        st_word.lane_b[req_i.addr[1:0]] = req_i.wdata[7:0];
        st_strb[req_i.addr[1:0]]        = 1'b1;
      end
      MEM_SIZE_H: begin
        // Upper or lower half by addr[1]
        st_word.lane_h[req_i.addr[1]]       = req_i.wdata[15:0];
        st_strb[{req_i.addr[1], 1'b0} +: 2] = 2'b11;
      end
      default: begin
        st_word = req_i.wdata;
        st_strb = '1;
      end
    endcase
  end

  // ==================================================
  // Data memory port
  // ==================================================
  // Misaligned accesses never reach memory
  assign dmem_ren_o   = accept && !req_i.is_write && !misalign;
  assign dmem_we_o    = accept && req_i.is_write && !misalign;
  assign dmem_addr_o  = {req_i.addr[`MEM_XLEN-1:2], 2'b00};
  assign dmem_wdata_o = st_word;
  assign dmem_wstrb_o = req_i.is_write ? st_strb : '0;

  // Push in the acceptance cycle, read word taken as is
  assign push_o = accept;

  always_comb begin
    entry_o.is_load   = !req_i.is_write;
    entry_o.funct3    = req_i.funct3;
    entry_o.addr_lo   = req_i.addr[1:0];
    entry_o.rd        = req_i.rd;
    entry_o.rdata     = dmem_rdata_i;
    entry_o.trap      = misalign;
    entry_o.trap_code = misalign ? MEM_TRAP_MISALIGN : MEM_TRAP_NONE;
  end

  // ==================================================
  // Credit counter
  // ==================================================
  // One credit per free retire queue slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt <= `MEM_CREDIT_W'(`MEM_FIFO_DEPTH);
    end else begin
      case ({push_o, credit_return_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        // Spend and return together leave it unchanged
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // A return beyond the depth means the queue popped a slot never pushed
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= `MEM_CREDIT_W'(`MEM_FIFO_DEPTH));

endmodule

`default_nettype wire

//--- mem_retire_fifo.sv
`default_nettype none

`include "mem_params.svh"

module mem_retire_fifo
  import mem_pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push_i,
  input  mem_entry_t entry_i,
  input  logic       pop_i,
  output mem_entry_t head_o,
  output logic       not_empty_o,
  output logic       credit_return_o
);

  localparam int PTR_W = $clog2(`MEM_FIFO_DEPTH);

  mem_entry_t               fifo_mem [`MEM_FIFO_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [`MEM_CREDIT_W-1:0] count;
  logic                     do_pop;
  logic                     full;

  assign not_empty_o = (count != '0);
  assign full        = (count == `MEM_CREDIT_W'(`MEM_FIFO_DEPTH));
  assign do_pop      = pop_i && not_empty_o;

  // Head visible right after the push edge
  assign head_o = fifo_mem[rd_ptr];

  // Credit goes back in the cycle of the pop
  assign credit_return_o = do_pop;

  // ==================================================
  // Storage
  // ==================================================
  always_ff @(posedge clk) begin
    if (push_i) begin
      fifo_mem[wr_ptr] <= entry_i;
    end
  end

  // ==================================================
  // Pointers and occupancy
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(`MEM_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`MEM_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer must hold a credit for every push
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !full);

  // Consumer only pops a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> not_empty_o);

endmodule

`default_nettype wire

//--- mem_load_writeback.sv
`default_nettype none

`include "mem_params.svh"

module mem_load_writeback
  import mem_op_pkg::*;
  import mem_pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  mem_entry_t head_i,
  input  logic       not_empty_i,
  output logic       pop_o,
  output logic       wb_valid_o,
  output mem_wb_t    wb_o,
  input  logic       wb_ready_i
);

  mem_size_e            ld_size;
  logic                 ld_unsigned;
  logic [7:0]           ld_byte;
  logic [15:0]          ld_half;
  logic [`MEM_XLEN-1:0] ld_ext;
  mem_wb_t              wb_next;

  // ==================================================
  // Load lane select and extension
  // ==================================================
  assign ld_size     = mem_size_e'(head_i.funct3[1:0]);
  assign ld_unsigned = head_i.funct3[2];

  // Same raw word, byte view and halfword view
  assign ld_byte = head_i.rdata.lane_b[head_i.addr_lo];
  assign ld_half = head_i.rdata.lane_h[head_i.addr_lo[1]];

  always_comb begin
    case (ld_size)
      MEM_SIZE_B: ld_ext = {{(`MEM_XLEN-8){ld_byte[7] & !ld_unsigned}}, ld_byte};
      MEM_SIZE_H: ld_ext = {{(`MEM_XLEN-16){ld_half[15] & !ld_unsigned}}, ld_half};
      // Word loads pass through
      default:    ld_ext = head_i.rdata;
    endcase
  end

  // Stores and traps retire without a register write
  always_comb begin
    wb_next.rd        = head_i.rd;
    wb_next.reg_write = head_i.is_load && !head_i.trap;
    wb_next.data      = wb_next.reg_write ? ld_ext : '0;
    wb_next.trap      = head_i.trap;
    wb_next.trap_code = head_i.trap_code;
  end

  // ==================================================
  // Output register
  // ==================================================
  // Pop when empty or draining in this same cycle
  assign pop_o = not_empty_i && (!wb_valid_o || wb_ready_i);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid_o <= 1'b0;
    end else if (pop_o) begin
      wb_valid_o <= 1'b1;
    end else if (wb_ready_i) begin
      wb_valid_o <= 1'b0;
    end
  end

  // Payload only moves on a pop
  always_ff @(posedge clk) begin
    if (pop_o) begin
      wb_o <= wb_next;
    end
  end

  // Result held until the consumer takes it
  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && !wb_ready_i) |=> (wb_valid_o && $stable(wb_o)));

endmodule

`default_nettype wire

//--- mem_stage_top.sv
`default_nettype none

`include "mem_params.svh"

module mem_stage_top
  import mem_op_pkg::*;
  import mem_pipe_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid_i,
  input  mem_req_t               req_i,
  output logic                   req_ready_o,
  output logic                   dmem_ren_o,
  output logic                   dmem_we_o,
  output logic [`MEM_XLEN-1:0]   dmem_addr_o,
  output logic [`MEM_XLEN-1:0]   dmem_wdata_o,
  output logic [`MEM_STRB_W-1:0] dmem_wstrb_o,
  input  logic [`MEM_XLEN-1:0]   dmem_rdata_i,
  output logic                   wb_valid_o,
  output mem_wb_t                wb_o,
  input  logic                   wb_ready_i
);

  // Access unit to retire queue
  logic       push;
  mem_entry_t entry;
  logic       credit_return;

  // Retire queue to writeback
  mem_entry_t head;
  logic       not_empty;
  logic       pop;

  // ==================================================
  // Producer, buffer, consumer
  // ==================================================
  mem_access_unit u_access (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .dmem_ren_o     (dmem_ren_o),
    .dmem_we_o      (dmem_we_o),
    .dmem_addr_o    (dmem_addr_o),
    .dmem_wdata_o   (dmem_wdata_o),
    .dmem_wstrb_o   (dmem_wstrb_o),
    .dmem_rdata_i   (dmem_rdata_i),
    .credit_return_i(credit_return),
    .push_o         (push),
    .entry_o        (entry)
  );

  mem_retire_fifo u_retire (
    .clk            (clk),
    .rst_n          (rst_n),
    .push_i         (push),
    .entry_i        (entry),
    .pop_i          (pop),
    .head_o         (head),
    .not_empty_o    (not_empty),
    .credit_return_o(credit_return)
  );

  mem_load_writeback u_wb (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_i     (head),
    .not_empty_i(not_empty),
    .pop_o      (pop),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i)
  );

endmodule

`default_nettype wire

//--- tb_mem_stage.sv
`default_nettype none

`include "mem_params.svh"

module tb_mem_stage
  import mem_op_pkg::*;
  import mem_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  localparam int N_DIRECTED = 40;
  localparam int N_RAND     = 48;
  // Reset plus 8 cycles per directed and 16 per random request plus slack
  localparam int WATCH_CYCLES = 8 + N_DIRECTED * 8 + N_RAND * 16 + 200;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   req_valid;
  mem_req_t               req;
  logic                   req_ready;
  logic                   dmem_ren;
  logic                   dmem_we;
  logic [`MEM_XLEN-1:0]   dmem_addr;
  logic [`MEM_XLEN-1:0]   dmem_wdata;
  logic [`MEM_STRB_W-1:0] dmem_wstrb;
  logic [`MEM_XLEN-1:0]   dmem_rdata;
  logic                   wb_valid;
  mem_wb_t                wb;
  logic                   wb_ready = 1'b1;
  logic                   xfer;

  // Memory model and the shadow copy the expected values come from
  logic [`MEM_XLEN-1:0]   mem_model [64];
  logic [`MEM_XLEN-1:0]   shadow [64];
  // Expected results with the oldest at exp_rd
  mem_wb_t                exp_q [256];
  logic [7:0]             exp_wr;
  logic [7:0]             exp_rd;
  mem_wb_t                exp_head;
  // Expected port values for the request now on the bus
  logic                   exp_ren;
  logic                   exp_we;
  logic [`MEM_XLEN-1:0]   exp_addr;
  logic [`MEM_STRB_W-1:0] exp_strb;
  logic [`MEM_XLEN-1:0]   exp_mask;
  logic [`MEM_XLEN-1:0]   exp_wdata;
  logic [31:0]            stim_lfsr;
  logic [31:0]            rdy_lfsr = 32'h1f4bd3db;
  logic                   ready_rand;
  logic                   ready_level;
  int                     err_cnt;
  int                     err_base;
  int                     tests_run;
  int                     tests_failed;

  mem_stage_top dut (
    .clk(clk), .rst_n(rst_n),
    .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
    .dmem_ren_o(dmem_ren), .dmem_we_o(dmem_we), .dmem_addr_o(dmem_addr),
    .dmem_wdata_o(dmem_wdata), .dmem_wstrb_o(dmem_wstrb), .dmem_rdata_i(dmem_rdata),
    .wb_valid_o(wb_valid), .wb_o(wb), .wb_ready_i(wb_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==================================================
  // Helpers
  // ==================================================
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit with the newest bit lowest
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input int k);
    return 32'h5a3c0f00 ^ (32'(k) * 32'h9e3779b9);
  endfunction

  function automatic mem_req_t make_req(input logic w, input logic [2:0] f3,
                                        input logic [31:0] a, input logic [31:0] d,
                                        input logic [4:0] rd);
    mem_req_t r;
    r.is_write = w;
    r.funct3   = f3;
    r.addr     = a;
    r.wdata    = d;
    r.rd       = rd;
    return r;
  endfunction

  // Any load or store in the 64-word window including misaligned ones
  function automatic mem_req_t rand_req();
    logic [31:0] v;
    logic [31:0] a;
    logic [31:0] d;
    logic [1:0]  sz;
    logic        w;
    logic        u;
    v  = rand_bits(4);
    w  = v[3];
    u  = v[2];
    sz = (v[1:0] == 2'b11) ? 2'b10 : v[1:0];
    a  = rand_bits(8);
    d  = rand_bits(32);
    v  = rand_bits(5);
    return make_req(w, {u & !w, sz}, {24'h0, a[7:0]}, d, v[4:0]);
  endfunction

  function automatic logic misaligned(input mem_req_t r);
    case (r.funct3[1:0])
      2'b00:   return 1'b0;
      2'b01:   return r.addr[0];
      default: return |r.addr[1:0];
    endcase
  endfunction

  // Byte to lane addr[1:0] and half to half addr[1]
  function automatic logic [3:0] store_strb(input mem_req_t r);
    case (r.funct3[1:0])
      2'b00:   return 4'b0001 << r.addr[1:0];
      2'b01:   return 4'b0011 << {r.addr[1], 1'b0};
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  function automatic logic [31:0] load_value(input logic [31:0] w, input logic [2:0] f3,
                                             input logic [1:0] off);
    logic [31:0] sh;
    sh = w >> {off, 3'b000};
    case (f3[1:0])
      2'b00:   return {{24{sh[7] & !f3[2]}}, sh[7:0]};
      2'b01:   return {{16{sh[15] & !f3[2]}}, sh[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic drive_req(input mem_req_t r);
    req       = r;
    req_valid = 1'b1;
    exp_ren   = !r.is_write && !misaligned(r);
    exp_we    = r.is_write && !misaligned(r);
    exp_addr  = {r.addr[31:2], 2'b00};
    exp_strb  = store_strb(r);
    exp_mask  = lane_mask(exp_strb);
    // Replicated so that any lane the strobes pick holds the data
    exp_wdata = (r.funct3[1:0] == 2'b00) ? {4{r.wdata[7:0]}} :
                (r.funct3[1:0] == 2'b01) ? {2{r.wdata[15:0]}} : r.wdata;
  endtask

  // Shadow memory and expected result for an accepted request
  task automatic record_accept(input mem_req_t r);
    mem_wb_t e;
    logic    mis;
    mis         = misaligned(r);
    e           = '0;
    e.rd        = r.rd;
    e.trap      = mis;
    e.trap_code = mis ? MEM_TRAP_MISALIGN : MEM_TRAP_NONE;
    if (!mis && r.is_write) begin
      shadow[r.addr[7:2]] = (shadow[r.addr[7:2]] & ~exp_mask) | (exp_wdata & exp_mask);
    end else if (!mis) begin
      e.reg_write = 1'b1;
      e.data      = load_value(shadow[r.addr[7:2]], r.funct3, r.addr[1:0]);
    end
    exp_q[exp_wr] = e;
    exp_wr        = exp_wr + 8'd1;
  endtask

  // Held on the bus until a cycle with a credit and then for one edge
  task automatic send(input mem_req_t r);
    drive_req(r);
    while (!req_ready) begin
      @(posedge clk);
      #2;
    end
    record_accept(r);
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    exp_ren   = 1'b0;
    exp_we    = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_rd != exp_wr) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == err_base) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, err_cnt - err_base);
    end
    err_base = err_cnt;
  endtask

  // ==================================================
  // Memory model, ready pattern, expected queue pop
  // ==================================================
  assign dmem_rdata = mem_model[dmem_addr[7:2]];
  assign exp_head   = exp_q[exp_rd];
  assign xfer       = wb_valid && wb_ready;

  // Filled during reset and written under the strobes afterwards
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < 64; k++) begin
        mem_model[k] <= fill_word(k);
      end
    end else if (dmem_we) begin
      for (int k = 0; k < `MEM_STRB_W; k++) begin
        if (dmem_wstrb[k]) begin
          mem_model[dmem_addr[7:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin
    #2;
    if (ready_rand) begin
      rdy_lfsr = lfsr_next(rdy_lfsr);
      wb_ready = rdy_lfsr[0];
    end else begin
      wb_ready = ready_level;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_rd <= '0;
    end else if (xfer) begin
      exp_rd <= exp_rd + 8'd1;
    end
  end

  // ==================================================
  // Checks
  // ==================================================
  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
    (req_ready && !wb_valid && !dmem_ren && !dmem_we))
    else begin
      $display("Outputs not in their reset state after reset release");
      err_cnt++;
    end

  a_ren: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_ren == (req_valid && req_ready && exp_ren))
    else begin
      $display("FAILED dmem_ren_o exp=%h got=%h",
               $sampled(req_valid && req_ready && exp_ren), $sampled(dmem_ren));
      err_cnt++;
    end

  a_we: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we == (req_valid && req_ready && exp_we))
    else begin
      $display("FAILED dmem_we_o exp=%h got=%h",
               $sampled(req_valid && req_ready && exp_we), $sampled(dmem_we));
      err_cnt++;
    end

  a_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_ren || dmem_we) |-> dmem_addr == exp_addr)
    else begin
      $display("FAILED dmem_addr_o exp=%h got=%h", $sampled(exp_addr), $sampled(dmem_addr));
      err_cnt++;
    end

  a_strb: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> dmem_wstrb == exp_strb)
    else begin
      $display("FAILED dmem_wstrb_o exp=%h got=%h", $sampled(exp_strb), $sampled(dmem_wstrb));
      err_cnt++;
    end

  // Only the strobed lanes carry meaning
  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> (dmem_wdata & exp_mask) == (exp_wdata & exp_mask))
    else begin
      $display("FAILED dmem_wdata_o exp=%h got=%h",
               $sampled(exp_wdata & exp_mask), $sampled(dmem_wdata & exp_mask));
      err_cnt++;
    end

  a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
    xfer |-> exp_rd != exp_wr)
    else begin
      $display("Result transferred with no request outstanding");
      err_cnt++;
    end

  a_wb_regwrite: assert property (@(posedge clk) disable iff (!rst_n)
    xfer |-> wb.reg_write == exp_head.reg_write)
    else begin
      $display("FAILED wb_o.reg_write exp=%h got=%h",
               $sampled(exp_head.reg_write), $sampled(wb.reg_write));
      err_cnt++;
    end

  a_wb_rd: assert property (@(posedge clk) disable iff (!rst_n)
    (xfer && exp_head.reg_write) |-> wb.rd == exp_head.rd)
    else begin
      $display("FAILED wb_o.rd exp=%h got=%h", $sampled(exp_head.rd), $sampled(wb.rd));
      err_cnt++;
    end

  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
    (xfer && exp_head.reg_write) |-> wb.data == exp_head.data)
    else begin
      $display("FAILED wb_o.data exp=%h got=%h", $sampled(exp_head.data), $sampled(wb.data));
      err_cnt++;
    end

  a_wb_trap: assert property (@(posedge clk) disable iff (!rst_n)
    xfer |-> {wb.trap, wb.trap_code} == {exp_head.trap, exp_head.trap_code})
    else begin
      $display("FAILED wb_o.trap/trap_code exp=%h got=%h",
               $sampled({exp_head.trap, exp_head.trap_code}), $sampled({wb.trap, wb.trap_code}));
      err_cnt++;
    end

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb)))
    else begin
      $display("Writeback result changed or dropped while held by back-pressure");
      err_cnt++;
    end

  // ==================================================
  // Watchdog and test sequence
  // ==================================================
  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("Watchdog expired with %0d results outstanding", exp_wr - exp_rd);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    mem_req_t    r;
    logic [31:0] v;
    logic [31:0] base;
    logic        took;
    int          accepted;
    int          step;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    exp_wr      = '0;
    exp_ren     = 1'b0;
    exp_we      = 1'b0;
    exp_addr    = '0;
    exp_strb    = '0;
    exp_mask    = '0;
    exp_wdata   = '0;
    stim_lfsr   = 32'h1f4bd3db;
    ready_rand  = 1'b0;
    ready_level = 1'b1;
    err_cnt     = 0;
    err_base    = 0;
    tests_run   = 0;
    tests_failed = 0;
    for (int k = 0; k < 64; k++) begin
      shadow[k] = fill_word(k);
    end
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (2) begin
      @(posedge clk);
      #2;
    end
    end_test("reset state");

    // Every aligned offset per size before the merged word is read back
    for (int f = 0; f < 3; f++) begin
      base = 32'(16 * (f + 1));
      step = 1 << f;
      for (int off = 0; off < 4; off += step) begin
        send(make_req(1'b1, 3'(f), base + 32'(off), rand_bits(32), 5'd0));
      end
      send(make_req(1'b0, 3'b010, base, 32'h0, 5'(f + 1)));
    end
    wait_drain();
    end_test("store lanes");

    // LB, LH, LW, LBU, LHU at each aligned offset of one random word
    v    = rand_bits(6);
    base = {24'h0, v[5:0], 2'b00};
    for (int f = 0; f < 6; f++) begin
      if (f != 3) begin
        step = 1 << f[1:0];
        for (int off = 0; off < 4; off += step) begin
          v = rand_bits(5);
          send(make_req(1'b0, 3'(f), base + 32'(off), 32'h0, v[4:0]));
        end
      end
    end
    wait_drain();
    end_test("load extend");

    // Misaligned half and word in both directions before the word is read back
    send(make_req(1'b1, 3'b010, 32'h50, rand_bits(32), 5'd0));
    for (int f = 1; f < 3; f++) begin
      for (int off = 1; off < 4; off++) begin
        if (f == 2 || off != 2) begin
          send(make_req(1'b1, 3'(f), 32'h50 + 32'(off), rand_bits(32), 5'd9));
          send(make_req(1'b0, 3'(f), 32'h50 + 32'(off), 32'h0, 5'd10));
        end
      end
    end
    send(make_req(1'b0, 3'b101, 32'h51, 32'h0, 5'd11));
    send(make_req(1'b0, 3'b010, 32'h50, 32'h0, 5'd12));
    wait_drain();
    end_test("misaligned");

    // Output stalled so the queue and output register fill and ready drops
    ready_level = 1'b0;
    repeat (2) begin
      @(posedge clk);
      #2;
    end
    accepted = 0;
    r = rand_req();
    drive_req(r);
    repeat (12) begin
      took = req_ready;
      if (took) begin
        record_accept(r);
        accepted++;
      end
      @(posedge clk);
      #2;
      if (took) begin
        r = rand_req();
        drive_req(r);
      end
    end
    req_valid = 1'b0;
    exp_ren   = 1'b0;
    exp_we    = 1'b0;
    assert (accepted == `MEM_FIFO_DEPTH + 1 && !req_ready)
      else begin
        $display("Back-pressure let %0d requests in, expected %0d", accepted,
                 `MEM_FIFO_DEPTH + 1);
        err_cnt++;
      end
    ready_level = 1'b1;
    wait_drain();
    end_test("back-pressure");

    ready_rand = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      send(rand_req());
    end
    wait_drain();
    ready_rand = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #2;
    end
    assert (!wb_valid && exp_rd == exp_wr)
      else begin
        $display("Extra writeback result after all requests retired");
        err_cnt++;
      end
    end_test("random order");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
mem_op_pkg.sv
mem_pipe_pkg.sv
mem_access_unit.sv
mem_retire_fifo.sv
mem_load_writeback.sv
mem_stage_top.sv
tb_mem_stage.sv

//--- Makefile
# Verilator flow for the memory access stage

VERILATOR ?= verilator
TB_TOP    ?= tb_mem_stage
RTL_TOP   ?= mem_stage_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
RTL_SRCS  ?= mem_op_pkg.sv mem_pipe_pkg.sv mem_access_unit.sv mem_retire_fifo.sv \
             mem_load_writeback.sv mem_stage_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+. --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
